//--- source/ninjin_macros.svh
// ninjin shared constants
// bus widths, register count and register word indices

`ifndef NINJIN_MACROS_SVH
`define NINJIN_MACROS_SVH

// AXI4-Lite bus geometry
`define NINJIN_DATA_WIDTH 32
`define NINJIN_ADDR_WIDTH 7
`define NINJIN_LSB        2

// lower half host-to-logic, upper half logic-to-host
`define NINJIN_PORT       8

// host-to-logic words
`define REG_CTRL   0
`define REG_LEN    1
`define REG_OPA    2
`define REG_OPB    3

// logic-to-host words
`define REG_STATUS 4
`define REG_RESULT 5
`define REG_ITER   6
`define REG_RUNS   7

`endif

//--- source/ninjin_pkg.sv
// ninjin shared types
// register word type, engine opcodes and engine FSM states

`include "ninjin_macros.svh"

package ninjin_pkg;

  // one register word, also the AXI data width
  typedef logic [`NINJIN_DATA_WIDTH-1:0] word_t;

  // opcode field, ctrl bits 9:8
  typedef enum logic [1:0] {
    op_sum  = 2'd0,
    op_pow  = 2'd1,
    op_rsv2 = 2'd2,
    op_rsv3 = 2'd3
  } opcode_t;

  // sequence engine FSM
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_run  = 2'd1,
    st_done = 2'd2
  } engine_state_t;

endpackage

//--- source/ninjin_s_axi_lite.sv
// ninjin AXI4-Lite slave
// eight-word register file with byte-strobe writes; the upper four words
// are refreshed from the engine on every cycle without a write

`timescale 1ns/10ps

`include "ninjin_macros.svh"

module ninjin_s_axi_lite
  import ninjin_pkg::*;
(
  input  logic                            clk,
  input  logic                            xrst,
  input  logic [`NINJIN_ADDR_WIDTH-1:0]   awaddr,
  input  logic [2:0]                      awprot,
  input  logic                            awvalid,
  input  word_t                           wdata,
  input  logic [`NINJIN_DATA_WIDTH/8-1:0] wstrb,
  input  logic                            wvalid,
  input  logic                            bready,
  input  logic [`NINJIN_ADDR_WIDTH-1:0]   araddr,
  input  logic [2:0]                      arprot,
  input  logic                            arvalid,
  input  logic                            rready,
  input  word_t                           out_port [`NINJIN_PORT-1:`NINJIN_PORT/2],
  output logic                            awready,
  output logic                            wready,
  output logic                            bvalid,
  output logic [1:0]                      bresp,
  output logic                            arready,
  output logic                            rvalid,
  output word_t                           rdata,
  output logic [1:0]                      rresp,
  output word_t                           in_port [`NINJIN_PORT/2-1:0]
);

  localparam int IDX_W  = `NINJIN_ADDR_WIDTH - `NINJIN_LSB;
  localparam int STRB_W = `NINJIN_DATA_WIDTH / 8;

  logic                          wr_ready_q;
  logic                          bvalid_q;
  logic                          arready_q;
  logic                          rvalid_q;
  logic [`NINJIN_ADDR_WIDTH-1:0] waddr_q;
  logic [`NINJIN_ADDR_WIDTH-1:0] raddr_q;
  logic [IDX_W-1:0]              waddr_idx;
  logic [IDX_W-1:0]              raddr_idx;
  word_t                         rdata_q;
  word_t                         port_q [`NINJIN_PORT-1:0];
  word_t                         rd_mux [2**IDX_W-1:0];
  logic                          wr_accept;
  logic                          ar_accept;
  logic                          port_we;
  logic                          port_re;

  // prot inputs carry no meaning here, responses are always OKAY
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  // ========================================
  // write address / data channel
  // ========================================

  // one write in flight, so nothing new while a response is pending
  assign wr_accept = awvalid && wvalid && !wr_ready_q && !bvalid_q;
  assign port_we   = wr_ready_q && awvalid && wvalid;
  assign waddr_idx = waddr_q[`NINJIN_ADDR_WIDTH-1:`NINJIN_LSB];

  // awready and wready pulse together
  assign awready = wr_ready_q;
  assign wready  = wr_ready_q;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wr_ready_q <= 1'b0;
    end else begin
      wr_ready_q <= wr_accept;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      waddr_q <= awaddr;
    end
  end

  // ========================================
  // write response channel
  // ========================================

  assign bvalid = bvalid_q;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      bvalid_q <= 1'b0;
    end else if (port_we) begin
      bvalid_q <= 1'b1;
    end else if (bready) begin
      bvalid_q <= 1'b0;
    end
  end

  // ========================================
  // read address channel
  // ========================================

  assign ar_accept = arvalid && !arready_q && !rvalid_q;
  assign port_re   = arready_q && arvalid && !rvalid_q;
  assign raddr_idx = raddr_q[`NINJIN_ADDR_WIDTH-1:`NINJIN_LSB];
  assign arready   = arready_q;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      arready_q <= 1'b0;
    end else begin
      arready_q <= ar_accept;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_accept) begin
      raddr_q <= araddr;
    end
  end

  // ========================================
  // read data channel
  // ========================================

  // word indices past the register file read as zero
  for (genvar i = 0; i < 2**IDX_W; i++) begin : g_rd_mux
    if (i < `NINJIN_PORT) begin : g_reg
      assign rd_mux[i] = port_q[i];
    end else begin : g_zero
      assign rd_mux[i] = '0;
    end
  end

  assign rvalid = rvalid_q;
  assign rdata  = rdata_q;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      rvalid_q <= 1'b0;
    end else if (port_re) begin
      rvalid_q <= 1'b1;
    end else if (rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // captured once, held until rready
  always_ff @(posedge clk) begin
    if (port_re) begin
      rdata_q <= rd_mux[raddr_idx];
    end
  end

  // ========================================
  // register file
  // ========================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < `NINJIN_PORT; i++) begin
        port_q[i] <= '0;
      end
    end else if (port_we) begin
      for (int i = 0; i < `NINJIN_PORT; i++) begin
        if (waddr_idx == IDX_W'(i)) begin
          for (int b = 0; b < STRB_W; b++) begin
            if (wstrb[b]) begin
              port_q[i][b*8 +: 8] <= wdata[b*8 +: 8];
            end
          end
        end
      end
    end else begin
      // engine side refresh
      for (int i = `NINJIN_PORT/2; i < `NINJIN_PORT; i++) begin
        port_q[i] <= out_port[i];
      end
    end
  end

  for (genvar i = 0; i < `NINJIN_PORT/2; i++) begin : g_in_port
    assign in_port[i] = port_q[i];
  end

  // ========================================
  // assertions
  // ========================================

  a_bvalid_hold: assert property (
    @(posedge clk) disable iff (!xrst)
    bvalid_q && !bready |=> bvalid_q
  ) else $error("bvalid dropped before bready");

  a_rdata_hold: assert property (
    @(posedge clk) disable iff (!xrst)
    rvalid_q && !rready |=> rvalid_q && $stable(rdata_q)
  ) else $error("read data changed while stalled");

  // master must keep both valids up through the ready pulse
  a_wr_ready_valid: assert property (
    @(posedge clk) disable iff (!xrst)
    wr_ready_q |-> awvalid && wvalid
  ) else $error("awready/wready without matching valid");

endmodule

//--- source/ninjin_seq_engine.sv
// ninjin sequence engine
// runs one sum or power command per start edge, one iteration per cycle,
// and reports status, result, iteration count and run count

`timescale 1ns/10ps

`include "ninjin_macros.svh"

module ninjin_seq_engine
  import ninjin_pkg::*;
(
  input  logic  clk,
  input  logic  xrst,
  input  word_t ctrl,
  input  word_t len,
  input  word_t opa,
  input  word_t opb,
  output word_t status,
  output word_t result,
  output word_t iter_count,
  output word_t run_count
);

  // length field is the lower half word
  localparam int LEN_W = `NINJIN_DATA_WIDTH / 2;

  engine_state_t    state_q;
  opcode_t          op_in;
  opcode_t          op_q;
  logic             start_d;
  logic             start_pulse;
  logic             busy;
  logic             last_iter;
  logic             done_q;
  logic             err_q;
  logic [LEN_W-1:0] len_q;
  logic [LEN_W-1:0] iter_q;
  word_t            b_q;
  word_t            term_q;
  word_t            acc_q;
  word_t            runs_q;

  assign op_in       = opcode_t'(ctrl[9:8]);
  assign start_pulse = ctrl[0] && !start_d && (state_q == st_idle);
  assign busy        = (state_q == st_run);
  assign last_iter   = ((iter_q + 1'b1) == len_q);

  // start bit history for edge detect
  always_ff @(posedge clk) begin
    if (!xrst) begin
      start_d <= 1'b0;
    end else begin
      start_d <= ctrl[0];
    end
  end

  // ========================================
  // control FSM
  // ========================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state_q <= st_idle;
      len_q   <= '0;
      iter_q  <= '0;
      acc_q   <= '0;
      runs_q  <= '0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (start_pulse) begin
            len_q  <= len[LEN_W-1:0];
            iter_q <= '0;
            done_q <= 1'b0;
            err_q  <= 1'b0;
            if (op_in == op_sum || op_in == op_pow) begin
              // sum starts from 0, power from a
              acc_q   <= (op_in == op_pow) ? opa : '0;
              state_q <= (len[LEN_W-1:0] == '0) ? st_done : st_run;
            end else begin
              // reserved opcode, abort
              acc_q   <= '0;
              err_q   <= 1'b1;
              state_q <= st_done;
            end
          end
        end
        st_run: begin
          iter_q <= iter_q + 1'b1;
          if (op_q == op_pow) begin
            acc_q <= acc_q * b_q;
          end else begin
            acc_q <= acc_q + term_q;
          end
          if (last_iter) begin
            state_q <= st_done;
          end
        end
        st_done: begin
          done_q  <= 1'b1;
          runs_q  <= runs_q + 1'b1;
          state_q <= st_idle;
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // ========================================
  // operand latch and series term
  // ========================================

  always_ff @(posedge clk) begin
    if (start_pulse) begin
      op_q   <= op_in;
      b_q    <= opb;
      term_q <= opa;
    end else if (busy) begin
      term_q <= term_q + b_q;
    end
  end

  // status word: err, done, busy
  assign status     = {{(`NINJIN_DATA_WIDTH-3){1'b0}}, err_q, done_q, busy};
  assign result     = acc_q;
  assign iter_count = {{(`NINJIN_DATA_WIDTH-LEN_W){1'b0}}, iter_q};
  assign run_count  = runs_q;

  // ========================================
  // assertions
  // ========================================

  a_busy_done_excl: assert property (
    @(posedge clk) disable iff (!xrst)
    !(busy && done_q)
  ) else $error("busy and done set together");

  a_iter_bound: assert property (
    @(posedge clk) disable iff (!xrst)
    busy |=> iter_q <= len_q
  ) else $error("iteration count past latched length");

endmodule

//--- source/ninjin_top.sv
// ninjin top level
// AXI4-Lite register file steering the sequence engine

`timescale 1ns/10ps

`include "ninjin_macros.svh"

module ninjin_top
  import ninjin_pkg::*;
(
  input  logic                            clk,
  input  logic                            xrst,
  input  logic [`NINJIN_ADDR_WIDTH-1:0]   awaddr,
  input  logic [2:0]                      awprot,
  input  logic                            awvalid,
  input  word_t                           wdata,
  input  logic [`NINJIN_DATA_WIDTH/8-1:0] wstrb,
  input  logic                            wvalid,
  input  logic                            bready,
  input  logic [`NINJIN_ADDR_WIDTH-1:0]   araddr,
  input  logic [2:0]                      arprot,
  input  logic                            arvalid,
  input  logic                            rready,
  output logic                            awready,
  output logic                            wready,
  output logic                            bvalid,
  output logic [1:0]                      bresp,
  output logic                            arready,
  output logic                            rvalid,
  output word_t                           rdata,
  output logic [1:0]                      rresp
);

  word_t in_port  [`NINJIN_PORT/2-1:0];
  word_t out_port [`NINJIN_PORT-1:`NINJIN_PORT/2];

  word_t ctrl;
  word_t len;
  word_t opa;
  word_t opb;
  word_t status;
  word_t result;
  word_t iter_count;
  word_t run_count;

  // host-to-logic words
  assign ctrl = in_port[`REG_CTRL];
  assign len  = in_port[`REG_LEN];
  assign opa  = in_port[`REG_OPA];
  assign opb  = in_port[`REG_OPB];

  // logic-to-host words
  assign out_port[`REG_STATUS] = status;
  assign out_port[`REG_RESULT] = result;
  assign out_port[`REG_ITER]   = iter_count;
  assign out_port[`REG_RUNS]   = run_count;

  ninjin_s_axi_lite u_regs (
    .clk      (clk),
    .xrst     (xrst),
    .awaddr   (awaddr),
    .awprot   (awprot),
    .awvalid  (awvalid),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arprot   (arprot),
    .arvalid  (arvalid),
    .rready   (rready),
    .out_port (out_port),
    .awready  (awready),
    .wready   (wready),
    .bvalid   (bvalid),
    .bresp    (bresp),
    .arready  (arready),
    .rvalid   (rvalid),
    .rdata    (rdata),
    .rresp    (rresp),
    .in_port  (in_port)
  );

  ninjin_seq_engine u_engine (
    .clk        (clk),
    .xrst       (xrst),
    .ctrl       (ctrl),
    .len        (len),
    .opa        (opa),
    .opb        (opb),
    .status     (status),
    .result     (result),
    .iter_count (iter_count),
    .run_count  (run_count)
  );

endmodule

//--- verif/ninjin_tb.sv
// ninjin testbench
// drives the AXI4-Lite port, runs sum, power and reserved commands
// and checks the results against a series model

`timescale 1ns/10ps

`include "ninjin_macros.svh"

module ninjin_tb
  import ninjin_pkg::*;
;

  localparam int TIMEOUT    = 100;
  localparam int POLL_LIMIT = 40;

  logic                            clk;
  logic                            xrst;
  logic [`NINJIN_ADDR_WIDTH-1:0]   awaddr;
  logic [2:0]                      awprot;
  logic                            awvalid;
  word_t                           wdata;
  logic [`NINJIN_DATA_WIDTH/8-1:0] wstrb;
  logic                            wvalid;
  logic                            bready;
  logic [`NINJIN_ADDR_WIDTH-1:0]   araddr;
  logic [2:0]                      arprot;
  logic                            arvalid;
  logic                            rready;
  logic                            awready;
  logic                            wready;
  logic                            bvalid;
  logic [1:0]                      bresp;
  logic                            arready;
  logic                            rvalid;
  word_t                           rdata;
  logic [1:0]                      rresp;

  int    err_count;
  int    timeout_count;
  int    cmd_count;
  int    stall_max;
  word_t shadow [4];

  ninjin_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ========================================
  // reference model
  // ========================================

  function automatic word_t model_run(opcode_t op, int unsigned len, word_t a, word_t b);
    word_t acc;
    word_t term;
    acc  = '0;
    term = a;
    if (op == op_sum) begin
      for (int i = 0; i < len; i++) begin
        acc  = acc + term;
        term = term + b;
      end
    end else if (op == op_pow) begin
      acc = a;
      for (int i = 0; i < len; i++) begin
        acc = acc * b;
      end
    end
    return acc;
  endfunction

  function automatic word_t merge_bytes(word_t old_val, word_t new_val, logic [3:0] strb);
    word_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_value(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      err_count++;
    end
  endtask

  // ========================================
  // bus tasks entered and left on a falling edge
  // ========================================

  task automatic axi_write(input int idx, input word_t data, input logic [3:0] strb);
    int cnt;
    int hold;
    awaddr  = idx << `NINJIN_LSB;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    cnt     = 0;
    @(negedge clk);
    while (!(awready && wready) && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!(awready && wready)) begin
      $display("timeout waiting for awready and wready on word %0d", idx);
      timeout_count++;
    end
    // transfer happens on the edge after ready is seen
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    cnt     = 0;
    while (!bvalid && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!bvalid) begin
      $display("timeout waiting for bvalid on word %0d", idx);
      timeout_count++;
    end else if (bresp !== 2'b00) begin
      $display("error %0t: bresp 0x%0h on word %0d, expected OKAY", $time, bresp, idx);
      err_count++;
    end
    hold = $urandom % (stall_max + 1);
    repeat (hold) begin
      @(negedge clk);
      if (!bvalid) begin
        $display("error %0t: bvalid dropped while bready was low", $time);
        err_count++;
      end
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input int idx, output word_t data);
    int    cnt;
    int    hold;
    word_t first;
    araddr  = idx << `NINJIN_LSB;
    arvalid = 1'b1;
    cnt     = 0;
    @(negedge clk);
    while (!arready && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!arready) begin
      $display("timeout waiting for arready on word %0d", idx);
      timeout_count++;
    end
    @(negedge clk);
    arvalid = 1'b0;
    cnt     = 0;
    while (!rvalid && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!rvalid) begin
      $display("timeout waiting for rvalid on word %0d", idx);
      timeout_count++;
    end else if (rresp !== 2'b00) begin
      $display("error %0t: rresp 0x%0h on word %0d, expected OKAY", $time, rresp, idx);
      err_count++;
    end
    first = rdata;
    hold  = $urandom % (stall_max + 1);
    repeat (hold) begin
      @(negedge clk);
      if (!rvalid || rdata !== first) begin
        $display("error %0t: read data not held while rready was low", $time);
        err_count++;
      end
    end
    data   = first;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // host-to-logic write that also updates the shadow copy
  task automatic write_reg(input int idx, input word_t data, input logic [3:0] strb);
    axi_write(idx, data, strb);
    shadow[idx] = merge_bytes(shadow[idx], data, strb);
  endtask

  task automatic run_command(input opcode_t op, input logic [15:0] len, input word_t a,
                             input word_t b);
    word_t status;
    word_t got;
    word_t exp_status;
    int    polls;
    logic  valid_op;
    valid_op = (op == op_sum) || (op == op_pow);
    write_reg(`REG_LEN, {16'h0, len}, 4'hf);
    write_reg(`REG_OPA, a, 4'hf);
    write_reg(`REG_OPB, b, 4'hf);
    write_reg(`REG_CTRL, {22'h0, op, 7'h0, 1'b1}, 4'hf);
    status = '0;
    polls  = 0;
    while (!status[1] && polls < POLL_LIMIT) begin
      axi_read(`REG_STATUS, status);
      polls++;
    end
    if (!status[1]) begin
      $display("timeout waiting for the engine to report done");
      timeout_count++;
    end
    cmd_count++;
    exp_status = valid_op ? 32'h2 : 32'h6;
    check_value("status", status, exp_status);
    axi_read(`REG_RESULT, got);
    check_value("result", got, model_run(op, len, a, b));
    axi_read(`REG_ITER, got);
    check_value("iter_count", got, valid_op ? {16'h0, len} : 32'h0);
    // drop start so the next command sees a fresh edge
    write_reg(`REG_CTRL, 32'h0, 4'hf);
  endtask

  // ========================================
  // scenarios
  // ========================================

  initial begin
    int          idx;
    word_t       data;
    word_t       got;
    logic [3:0]  strb;

    xrst    = 1'b0;
    awaddr  = '0;
    awprot  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arprot  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    err_count     = 0;
    timeout_count = 0;
    cmd_count     = 0;
    stall_max     = 0;
    for (int i = 0; i < 4; i++) begin
      shadow[i] = '0;
    end
    void'($urandom(32'h7360));

    repeat (10) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;

    // handshake outputs idle out of reset
    if ({awready, wready, bvalid, arready, rvalid} !== 5'b0) begin
      $display("error %0t: handshake outputs not low after reset", $time);
      err_count++;
    end

    // reset values of mapped and unmapped word indices
    for (int i = 0; i < 32; i++) begin
      axi_read(i, got);
      check_value("reset word", got, 32'h0);
    end

    // byte strobe merge on host-to-logic words
    for (int n = 0; n < 16; n++) begin
      idx  = $urandom % 4;
      data = $urandom;
      strb = $urandom;
      if (idx == `REG_CTRL) begin
        data[0] = 1'b0;
      end
      write_reg(idx, data, strb);
      axi_read(idx, got);
      check_value("strobe write", got, shadow[idx]);
    end
    axi_write(`REG_RESULT, $urandom | 32'h1, 4'hf);
    axi_read(`REG_RESULT, got);
    check_value("sampled result word", got, 32'h0);
    write_reg(`REG_CTRL, 32'h0, 4'hf);

    repeat (20) run_command(op_sum, $urandom % 21, $urandom, $urandom);
    repeat (20) run_command(op_pow, $urandom % 21, $urandom, $urandom);

    // reserved opcodes abort with err
    run_command(op_rsv2, $urandom % 21, $urandom, $urandom);
    run_command(op_rsv3, $urandom % 21, $urandom, $urandom);
    axi_read(`REG_RUNS, got);
    check_value("run_count", got, cmd_count);

    // back-pressure on both response channels
    stall_max = 10;
    for (int n = 0; n < 8; n++) begin
      idx = 1 + ($urandom % 3);
      write_reg(idx, $urandom, $urandom);
      axi_read(idx, got);
      check_value("stalled read", got, shadow[idx]);
    end
    run_command(op_sum, $urandom % 21, $urandom, $urandom);
    axi_read(`REG_RUNS, got);
    check_value("run_count", got, cmd_count);

    $display("errors %0d, timeouts %0d, commands %0d", err_count, timeout_count, cmd_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+source
source/ninjin_pkg.sv
source/ninjin_s_axi_lite.sv
source/ninjin_seq_engine.sv
source/ninjin_top.sv
verif/ninjin_tb.sv

//--- Bender.yml
package:
  name: ninjin

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/ninjin_pkg.sv
      - source/ninjin_s_axi_lite.sv
      - source/ninjin_seq_engine.sv
      - source/ninjin_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - verif/ninjin_tb.sv
